/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_matmul
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/matmul_pkg.sv */
package matmul_pkg;

  // element width in bits
  localparam int DWIDTH = 8;

  // rows and columns of both operands and of the result
  localparam int MAT_SIZE = 4;
  localparam int LOG2_MAT_SIZE = 2;

  // on-chip memory geometry
  localparam int AWIDTH = 7;
  localparam int MEM_SIZE = 128;

  // one matrix element
  typedef logic [DWIDTH-1:0] elem_t;

  // one memory word, lane r sits in bits 8r+7 down to 8r
  typedef logic [MAT_SIZE*DWIDTH-1:0] word_t;

  // word address into any of the three memories
  typedef logic [AWIDTH-1:0] addr_t;

endpackage

/* common/matmul_sched_pkg.sv */
package matmul_sched_pkg;

  // multiply stage plus accumulate stage
  localparam int NUM_CYCLES_IN_MAC = 2;

  // one operand address per cycle, k = 0..3
  localparam int FEED_CYCLES = 4;

  // counter value where row 0 is final
  // last word leaves memory at FEED_CYCLES, walks MAT_SIZE-1 columns east,
  // then needs the MAC pipeline before it shows in the sum
  localparam int LATCH_BASE = FEED_CYCLES + matmul_pkg::MAT_SIZE - 1 + NUM_CYCLES_IN_MAC;

  localparam int CNT_WIDTH = 5;

  // run cycle counter
  typedef logic [CNT_WIDTH-1:0] cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    FEED,
    WAIT_DRAIN,
    DONE
  } ctrl_state_t;

endpackage

/* common/operand_if.sv */
`timescale 1ns/1ps

interface operand_if;

  // operand read addresses from the controller
  matmul_pkg::addr_t a_addr;
  matmul_pkg::addr_t b_addr;

  // marks a cycle whose addresses carry real operands
  logic rd_en;

  // read words, one cycle behind the addresses
  matmul_pkg::word_t a_data;
  matmul_pkg::word_t b_data;

  modport mem (
    input  a_addr,
    input  b_addr,
    input  rd_en,
    output a_data,
    output b_data
  );

  // controller drives addresses, the array only reads data
  modport array (
    output a_addr,
    output b_addr,
    output rd_en,
    input  a_data,
    input  b_data
  );

endinterface

/* design/matmul_top.sv */
`timescale 1ns/1ps

module matmul_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable_writing_to_mem,
  input  logic              enable_reading_from_mem,
  input  logic              we_a,
  input  logic              we_b,
  input  matmul_pkg::word_t data_pi,
  input  matmul_pkg::addr_t addr_pi,
  output matmul_pkg::word_t data_from_out_mat,
  input  logic              start_mat_mul,
  output logic              done_mat_mul
);

  localparam int N = matmul_pkg::MAT_SIZE;

  // operand addresses out, operand words back
  operand_if ops ();

  logic clear;
  logic drain_done;
  logic [N-1:0] row_latch;
  matmul_pkg::elem_t [N-1:0][N-1:0] results;

  // drain to memory C
  logic c_we;
  matmul_pkg::addr_t c_addr;
  matmul_pkg::word_t c_data;

  matrix_memories u_mem (
    .clk                     (clk),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .ops                     (ops.mem),
    .c_we                    (c_we),
    .c_addr                  (c_addr),
    .c_data                  (c_data),
    .data_from_out_mat       (data_from_out_mat)
  );

  mac_controller u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .drain_done    (drain_done),
    .done_mat_mul  (done_mat_mul),
    .clear         (clear),
    .row_latch     (row_latch),
    .ops           (ops.array)
  );

  systolic_array u_array (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .ops     (ops.array),
    .results (results)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .results    (results),
    .row_latch  (row_latch),
    .c_we       (c_we),
    .c_addr     (c_addr),
    .c_data     (c_data),
    .drain_done (drain_done)
  );

endmodule

/* design/matrix_memories.sv */
`timescale 1ns/1ps

module matrix_memories (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable_writing_to_mem,
  input  logic              enable_reading_from_mem,
  input  logic              we_a,
  input  logic              we_b,
  input  matmul_pkg::word_t data_pi,
  input  matmul_pkg::addr_t addr_pi,
  operand_if.mem            ops,
  input  logic              c_we,
  input  matmul_pkg::addr_t c_addr,
  input  matmul_pkg::word_t c_data,
  output matmul_pkg::word_t data_from_out_mat
);

  // host side registers
  logic wr_mode_q;
  logic rd_mode_q;
  logic we_a_q;
  logic we_b_q;
  matmul_pkg::addr_t addr_q;
  matmul_pkg::word_t data_q;

  // operand read tracking
  logic op_rd_q;
  matmul_pkg::addr_t a_addr_sel;
  matmul_pkg::addr_t b_addr_sel;
  matmul_pkg::word_t a_rd;
  matmul_pkg::word_t b_rd;

  // memory C write and read port
  logic c_we_q;
  matmul_pkg::addr_t c_addr_q;
  matmul_pkg::word_t c_data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_mode_q <= 1'b0;
      rd_mode_q <= 1'b0;
      we_a_q    <= 1'b0;
      we_b_q    <= 1'b0;
      op_rd_q   <= 1'b0;
      c_we_q    <= 1'b0;
    end else begin
      wr_mode_q <= enable_writing_to_mem;
      rd_mode_q <= enable_reading_from_mem;
      // strobes move with their address and data
      we_a_q    <= we_a;
      we_b_q    <= we_b;
      op_rd_q   <= ops.rd_en;
      c_we_q    <= c_we;
    end
  end

  always_ff @(posedge clk) begin
    addr_q   <= addr_pi;
    data_q   <= data_pi;
    // host read wins over the drain, they never overlap
    c_addr_q <= rd_mode_q ? addr_q : c_addr;
    c_data_q <= c_data;
  end

  // host owns A and B during loading
  assign a_addr_sel = wr_mode_q ? addr_q : ops.a_addr;
  assign b_addr_sel = wr_mode_q ? addr_q : ops.b_addr;

  single_port_ram ram_a (
    .clk  (clk),
    .we   (we_a_q & wr_mode_q),
    .addr (a_addr_sel),
    .data (data_q),
    .out  (a_rd)
  );

  single_port_ram ram_b (
    .clk  (clk),
    .we   (we_b_q & wr_mode_q),
    .addr (b_addr_sel),
    .data (data_q),
    .out  (b_rd)
  );

  // zeros outside the feed window keep the array sums clean
  assign ops.a_data = op_rd_q ? a_rd : '0;
  assign ops.b_data = op_rd_q ? b_rd : '0;

  // read latency host reg + address reg + ram
  single_port_ram ram_c (
    .clk  (clk),
    .we   (c_we_q),
    .addr (c_addr_q),
    .data (c_data_q),
    .out  (data_from_out_mat)
  );

endmodule

/* design/result_drain.sv */
`timescale 1ns/1ps

module result_drain (
  input  logic clk,
  input  logic reset,
  input  matmul_pkg::elem_t [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::MAT_SIZE-1:0] results,
  input  logic [matmul_pkg::MAT_SIZE-1:0] row_latch,
  output logic              c_we,
  output matmul_pkg::addr_t c_addr,
  output matmul_pkg::word_t c_data,
  output logic              drain_done
);

  localparam int N = matmul_pkg::MAT_SIZE;
  localparam int W = matmul_pkg::DWIDTH;

  // snapshot of finished rows, row_q[r][c]
  matmul_pkg::elem_t [N-1:0][N-1:0] row_q;

  logic active;
  logic [matmul_pkg::LOG2_MAT_SIZE-1:0] col;

  // each row lands on its own strobe
  always_ff @(posedge clk) begin
    for (int r = 0; r < N; r++) begin
      if (row_latch[r]) begin
        row_q[r] <= results[r];
      end
    end
  end

  // column walk starts after the bottom row is in
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      col    <= '0;
    end else if (row_latch[N-1]) begin
      active <= 1'b1;
      col    <= '0;
    end else if (active) begin
      col <= col + 1'b1;
      if (col == (N - 1)) begin
        active <= 1'b0;
      end
    end
  end

  // column word, lane r is C[r][col]
  always_comb begin
    for (int r = 0; r < N; r++) begin
      c_data[r*W +: W] = row_q[r][col];
    end
  end

  assign c_we       = active;
  assign c_addr     = matmul_pkg::addr_t'(col);
  assign drain_done = active && (col == (N - 1));

endmodule

/* design/single_port_ram.sv */
`timescale 1ns/1ps

module single_port_ram (
  input  logic              clk,
  input  logic              we,
  input  matmul_pkg::addr_t addr,
  input  matmul_pkg::word_t data,
  output matmul_pkg::word_t out
);

  // storage, contents undefined until written
  matmul_pkg::word_t mem [matmul_pkg::MEM_SIZE];

  // write and registered read share the one address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= data;
    end
    // old word comes out on a same-cycle write
    out <= mem[addr];
  end

endmodule

/* systolic/mac_controller.sv */
`timescale 1ns/1ps

module mac_controller (
  input  logic clk,
  input  logic reset,
  input  logic start_mat_mul,
  input  logic drain_done,
  output logic done_mat_mul,
  output logic clear,
  output logic [matmul_pkg::MAT_SIZE-1:0] row_latch,
  operand_if.array ops
);

  localparam matmul_pkg::addr_t PARK_ADDR = matmul_pkg::addr_t'(matmul_pkg::MEM_SIZE - 1);

  matmul_sched_pkg::ctrl_state_t state;
  matmul_sched_pkg::cnt_t cnt;
  matmul_pkg::addr_t op_addr;
  logic rd_en_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= matmul_sched_pkg::IDLE;
      cnt          <= '0;
      op_addr      <= PARK_ADDR;
      rd_en_q      <= 1'b0;
      clear        <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      // single cycle pulse
      clear <= 1'b0;
      if (!start_mat_mul) begin
        // end of handshake or abort
        state        <= matmul_sched_pkg::IDLE;
        op_addr      <= PARK_ADDR;
        rd_en_q      <= 1'b0;
        done_mat_mul <= 1'b0;
      end else begin
        case (state)
          matmul_sched_pkg::IDLE: begin
            state   <= matmul_sched_pkg::FEED;
            cnt     <= '0;
            op_addr <= '0;
            rd_en_q <= 1'b1;
            // wipe accumulators of the last run
            clear   <= 1'b1;
          end
          matmul_sched_pkg::FEED: begin
            cnt <= cnt + 1'b1;
            if (cnt == matmul_sched_pkg::cnt_t'(matmul_sched_pkg::FEED_CYCLES - 1)) begin
              state   <= matmul_sched_pkg::WAIT_DRAIN;
              op_addr <= PARK_ADDR;
              rd_en_q <= 1'b0;
            end else begin
              op_addr <= op_addr + 1'b1;
            end
          end
          matmul_sched_pkg::WAIT_DRAIN: begin
            cnt <= cnt + 1'b1;
            // last column word goes out this cycle
            if (drain_done) begin
              state        <= matmul_sched_pkg::DONE;
              done_mat_mul <= 1'b1;
            end
          end
          default: begin
            // hold done until the host lets go
            done_mat_mul <= 1'b1;
          end
        endcase
      end
    end
  end

  // row r is final LATCH_BASE + r counts into the run
  always_comb begin
    for (int r = 0; r < matmul_pkg::MAT_SIZE; r++) begin
      row_latch[r] = (state == matmul_sched_pkg::WAIT_DRAIN) &&
                     (cnt == matmul_sched_pkg::cnt_t'(matmul_sched_pkg::LATCH_BASE + r));
    end
  end

  // k-th column of A and k-th row of B share address k
  assign ops.a_addr = op_addr;
  assign ops.b_addr = op_addr;
  assign ops.rd_en  = rd_en_q;

endmodule

/* systolic/processing_element.sv */
`timescale 1ns/1ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::elem_t in_a,
  input  matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t out_a,
  output matmul_pkg::elem_t out_b,
  output matmul_pkg::elem_t out_c
);

  logic [2*matmul_pkg::DWIDTH-1:0] prod_full;
  matmul_pkg::elem_t prod_q;
  matmul_pkg::elem_t acc_q;

  assign prod_full = in_a * in_b;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      prod_q <= '0;
      acc_q  <= '0;
      out_a  <= '0;
      out_b  <= '0;
    end else begin
      // stage 1, keep low byte of product
      prod_q <= prod_full[matmul_pkg::DWIDTH-1:0];
      // stage 2, wraps modulo 256
      acc_q  <= acc_q + prod_q;
      // neighbours east and south see operands next cycle
      out_a  <= in_a;
      out_b  <= in_b;
    end
  end

  assign out_c = acc_q;

endmodule

/* systolic/systolic_array.sv */
`timescale 1ns/1ps

module systolic_array (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  operand_if.array ops,
  output matmul_pkg::elem_t [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::MAT_SIZE-1:0] results
);

  localparam int N = matmul_pkg::MAT_SIZE;
  localparam int W = matmul_pkg::DWIDTH;

  // a moves east along a row, b moves south along a column
  // column N of a_h and row N of b_v run off the array edge
  matmul_pkg::elem_t a_h [N][N+1];
  matmul_pkg::elem_t b_v [N+1][N];

  // input skew, lane r held back r cycles
  for (genvar r = 0; r < N; r++) begin : g_lane
    if (r == 0) begin : g_direct
      assign a_h[0][0] = ops.a_data[W-1:0];
      assign b_v[0][0] = ops.b_data[W-1:0];
    end else begin : g_skew
      matmul_pkg::elem_t a_dly [r];
      matmul_pkg::elem_t b_dly [r];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int i = 0; i < r; i++) begin
            a_dly[i] <= '0;
            b_dly[i] <= '0;
          end
        end else begin
          a_dly[0] <= ops.a_data[r*W +: W];
          b_dly[0] <= ops.b_data[r*W +: W];
          for (int i = 1; i < r; i++) begin
            a_dly[i] <= a_dly[i-1];
            b_dly[i] <= b_dly[i-1];
          end
        end
      end

      // a lane r feeds row r, b lane r feeds column r
      assign a_h[r][0] = a_dly[r-1];
      assign b_v[0][r] = b_dly[r-1];
    end
  end

  // pairs A[r][k], B[k][c] meet in cell (r,c) on one wavefront
  for (genvar r = 0; r < N; r++) begin : g_row
    for (genvar c = 0; c < N; c++) begin : g_col
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_h[r][c]),
        .in_b  (b_v[r][c]),
        .out_a (a_h[r][c+1]),
        .out_b (b_v[r+1][c]),
        .out_c (results[r][c])
      );
    end
  end

endmodule

/* tb.f */
common/matmul_pkg.sv
common/matmul_sched_pkg.sv
common/operand_if.sv
design/single_port_ram.sv
design/matrix_memories.sv
systolic/processing_element.sv
systolic/systolic_array.sv
systolic/mac_controller.sv
design/result_drain.sv
design/matmul_top.sv
testbench/clock_gen.sv
testbench/tb_matmul.sv

/* testbench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
  output logic clk
);

  // 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
  end

  // free running, rising edges at 50, 150, 250 ns
  always begin
    #(HALF_PERIOD);
    clk = ~clk;
  end

endmodule

/* testbench/tb_matmul.sv */
`timescale 1ns/1ps

module tb_matmul;

  localparam int N = matmul_pkg::MAT_SIZE;
  localparam int W = matmul_pkg::DWIDTH;
  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  // random, overflow, three back to back, untouched
  localparam int NUM_RUNS = 6;
  localparam int RUN_CYCLES = 200;
  // load, result reads and idle gaps per run
  localparam int HOST_CYCLES = 40;

  logic clk;
  logic reset;
  logic enable_writing_to_mem;
  logic enable_reading_from_mem;
  logic we_a;
  logic we_b;
  matmul_pkg::word_t data_pi;
  matmul_pkg::addr_t addr_pi;
  matmul_pkg::word_t data_from_out_mat;
  logic start_mat_mul;
  logic done_mat_mul;

  integer seed = 65889;
  // operands as the host sees them, a_mat[row][col]
  matmul_pkg::elem_t a_mat [N][N];
  matmul_pkg::elem_t b_mat [N][N];
  matmul_pkg::word_t rd_word;
  matmul_pkg::word_t keep_word;

  clock_gen u_clk (
    .clk (clk)
  );

  matmul_top UUT (
    .clk                     (clk),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .data_from_out_mat       (data_from_out_mat),
    .start_mat_mul           (start_mat_mul),
    .done_mat_mul            (done_mat_mul)
  );

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %0h actual %0h", test_name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // elements in lo .. lo+span-1
  task automatic fill_matrices(input int lo, input int span);
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = matmul_pkg::elem_t'(lo + ($unsigned($random(seed)) % span));
        b_mat[r][c] = matmul_pkg::elem_t'(lo + ($unsigned($random(seed)) % span));
      end
    end
  endtask

  // C[r][j] = sum over k of A[r][k]*B[k][j], wrapped to 8 bits
  function automatic matmul_pkg::elem_t model_elem(input int r, input int j);
    int sum;
    sum = 0;
    for (int k = 0; k < N; k++) begin
      sum += a_mat[r][k] * b_mat[k][j];
    end
    return matmul_pkg::elem_t'(sum % 256);
  endfunction

  task automatic write_word(input logic to_b, input matmul_pkg::addr_t addr,
                            input matmul_pkg::word_t data);
    @(posedge clk);
    enable_writing_to_mem <= 1'b1;
    we_a    <= !to_b;
    we_b    <= to_b;
    addr_pi <= addr;
    data_pi <= data;
  endtask

  // all host strobes low, plus one cycle for the registered modes to follow
  task automatic release_host();
    @(posedge clk);
    enable_writing_to_mem   <= 1'b0;
    enable_reading_from_mem <= 1'b0;
    we_a <= 1'b0;
    we_b <= 1'b0;
    @(posedge clk);
  endtask

  // word k of A holds column k, word k of B holds row k
  task automatic load_matrices();
    matmul_pkg::word_t word_a;
    matmul_pkg::word_t word_b;
    for (int k = 0; k < N; k++) begin
      for (int r = 0; r < N; r++) begin
        word_a[r*W +: W] = a_mat[r][k];
        word_b[r*W +: W] = b_mat[k][r];
      end
      write_word(1'b0, matmul_pkg::addr_t'(k), word_a);
      write_word(1'b1, matmul_pkg::addr_t'(k), word_b);
    end
    release_host();
  endtask

  // word shows 3 cycles after the address, sampled mid cycle
  task automatic read_word(input matmul_pkg::addr_t addr, output matmul_pkg::word_t data);
    @(posedge clk);
    enable_reading_from_mem <= 1'b1;
    addr_pi <= addr;
    repeat (3) @(posedge clk);
    @(negedge clk);
    data = data_from_out_mat;
  endtask

  // full run including the done handshake
  task automatic run_multiply(input string test_name);
    int waited;
    waited = 0;
    @(posedge clk);
    start_mat_mul <= 1'b1;
    @(negedge clk);
    while (!done_mat_mul) begin
      if (waited == RUN_CYCLES) begin
        $display("done_mat_mul did not rise within %0d cycles in %s", RUN_CYCLES, test_name);
        $display("Checks failed");
        $fatal(1, "run timed out");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    // done must stay up while start is still held
    repeat (5) begin
      @(negedge clk);
      check_value({test_name, " done held"}, 32'd1, done_mat_mul);
    end
    @(posedge clk);
    start_mat_mul <= 1'b0;
    // controller sees start low on the next edge
    @(posedge clk);
    @(negedge clk);
    check_value({test_name, " done dropped"}, 32'd0, done_mat_mul);
  endtask

  // lane r of word j is C[r][j]
  task automatic check_result(input string test_name);
    for (int j = 0; j < N; j++) begin
      read_word(matmul_pkg::addr_t'(j), rd_word);
      for (int r = 0; r < N; r++) begin
        check_value($sformatf("%s C[%0d][%0d]", test_name, r, j),
                    model_elem(r, j), rd_word[r*W +: W]);
      end
    end
    release_host();
  endtask

  initial begin
    reset = 1'b1;
    enable_writing_to_mem = 1'b0;
    enable_reading_from_mem = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
    data_pi = '0;
    addr_pi = '0;
    start_mat_mul = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("after reset done", 32'd0, done_mat_mul);

    fill_matrices(0, 256);
    load_matrices();
    run_multiply("random");
    check_result("random");

    // products and sums well past 255
    fill_matrices(100, 156);
    load_matrices();
    run_multiply("overflow");
    check_result("overflow");

    // stale sums would leak into the next result
    for (int i = 0; i < 3; i++) begin
      fill_matrices(0, 256);
      load_matrices();
      run_multiply($sformatf("back_to_back %0d", i));
      check_result($sformatf("back_to_back %0d", i));
    end

    // word 50 of C lies outside the drain window
    read_word(matmul_pkg::addr_t'(50), keep_word);
    release_host();
    fill_matrices(0, 256);
    load_matrices();
    run_multiply("untouched");
    check_result("untouched");
    read_word(matmul_pkg::addr_t'(50), rd_word);
    release_host();
    check_value("untouched C[50]", keep_word, rd_word);

    $display("All checks passed");
    $finish;
  end

  // whole sequence plus generous margin per run
  initial begin
    #((NUM_RUNS * (RUN_CYCLES + HOST_CYCLES) + RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Checks failed");
    $fatal(1, "simulation stopped by watchdog");
  end

endmodule
